/* Makefile */
TOP = tb_flit_endpoint

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flit_endpoint.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f flit_endpoint.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /^RESULT: PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* flit_endpoint.f */
+incdir+.
flit_endpoint_pkg.sv
vc_flit_queue.sv
packet_injector.sv
flit_receiver.sv
flit_endpoint.sv
tb_flit_endpoint.sv

/* flit_endpoint.sv */
`default_nettype none

`include "flit_endpoint_settings.svh"

module flit_endpoint #(
    parameter logic [`EP_ADDR_WIDTH-1:0] node_address = 8'h2a
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [`EP_TIME_WIDTH-1:0]       sim_time,
    input  flit_endpoint_pkg::packet_desc_t packet,
    input  logic                            packet_valid,
    output logic                            packet_request,
    output flit_endpoint_pkg::flit_t        flit_out [`EP_NUM_VCS],
    output logic [`EP_NUM_VCS-1:0]          flit_out_valid,
    input  logic [`EP_NUM_VCS-1:0]          dequeue,
    input  flit_endpoint_pkg::flit_t        flit_in,
    input  logic                            flit_in_valid,
    output logic [`EP_VC_WIDTH-1:0]         credit_vc,
    output logic                            credit_valid,
    output flit_endpoint_pkg::ep_stats_t    stats,
    output logic                            error,
    output logic                            is_quiescent
);
    import flit_endpoint_pkg::*;

    flit_t                  inj_flit;
    logic [`EP_NUM_VCS-1:0] inj_write;
    logic [`EP_NUM_VCS-1:0] oq_full;
    logic [`EP_NUM_VCS-1:0] oq_empty;
    logic [`EP_NUM_VCS-1:0] oq_overflow;
    logic                   rx_empty;
    logic                   rx_error;

    packet_injector #(
        .node_address (node_address)
    ) u_injector (
        .clock          (clock),
        .reset          (reset),
        .sim_time       (sim_time),
        .packet         (packet),
        .packet_valid   (packet_valid),
        .packet_request (packet_request),
        .queue_full     (oq_full),
        .inj_flit       (inj_flit),
        .inj_write      (inj_write)
    );

    // Output queues drained by the network
    genvar v;
    generate
        for (v = 0; v < `EP_NUM_VCS; v++)
        begin : g_output_queue
            vc_flit_queue u_queue (
                .clock      (clock),
                .reset      (reset),
                .write      (inj_write[v]),
                .read       (dequeue[v]),
                .write_flit (inj_flit),
                .read_flit  (flit_out[v]),
                .full       (oq_full[v]),
                .empty      (oq_empty[v]),
                .overflow   (oq_overflow[v])
            );
            assign flit_out_valid[v] = !oq_empty[v];
        end
    endgenerate

    flit_receiver #(
        .node_address (node_address)
    ) u_receiver (
        .clock         (clock),
        .reset         (reset),
        .sim_time      (sim_time),
        .flit_in       (flit_in),
        .flit_in_valid (flit_in_valid),
        .credit_vc     (credit_vc),
        .credit_valid  (credit_valid),
        .stats         (stats),
        .error         (rx_error),
        .rx_empty      (rx_empty)
    );

    // Idle injector and nothing left in any queue
    assign is_quiescent = packet_request && (&oq_empty) && rx_empty;
    assign error        = rx_error || (|oq_overflow);

endmodule

`default_nettype wire

/* flit_endpoint_pkg.sv */
`default_nettype none

`include "flit_endpoint_settings.svh"

package flit_endpoint_pkg;

    // Routing info carried in the body of a head flit
    typedef struct packed {
        logic [`EP_ADDR_WIDTH-1:0] dest;
        logic [`EP_ADDR_WIDTH-1:0] src;
    } head_info_t;

    // Head flits read the body as routing info
    // Body flits read it as a sequence number
    typedef union packed {
        head_info_t                  head;
        logic [2*`EP_ADDR_WIDTH-1:0] payload;
    } flit_body_u;

    typedef struct packed {
        logic                      head;
        logic                      tail;
        logic                      measure;
        logic [`EP_VC_WIDTH-1:0]   vc;
        logic [`EP_TIME_WIDTH-1:0] inj_time;
        flit_body_u                body;
    } flit_t;

    // Packet descriptor from the traffic source
    typedef struct packed {
        logic [`EP_ADDR_WIDTH-1:0] dest;
        logic [`EP_LEN_WIDTH-1:0]  len_m1;
        logic [`EP_VC_WIDTH-1:0]   vc;
        logic                      measure;
    } packet_desc_t;

    // Receive statistics over measured packets only
    typedef struct packed {
        logic [15:0] packets;
        logic [31:0] latency_sum;
    } ep_stats_t;

endpackage

`default_nettype wire

/* flit_endpoint_settings.svh */
`ifndef FLIT_ENDPOINT_SETTINGS_SVH
`define FLIT_ENDPOINT_SETTINGS_SVH

// Node address width
`define EP_ADDR_WIDTH 8

// Timestamp width shared by sim_time and the flit injection time
`define EP_TIME_WIDTH 16

// Virtual channels and the index that selects one
`define EP_NUM_VCS 2
`define EP_VC_WIDTH 1

// Flits held by each VC queue
`define EP_QUEUE_DEPTH 4

// Packet length field holds length minus one for 1 to 8 flits
`define EP_LEN_WIDTH 3

`endif

/* flit_receiver.sv */
`default_nettype none

`include "flit_endpoint_settings.svh"

module flit_receiver #(
    parameter logic [`EP_ADDR_WIDTH-1:0] node_address = '0
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [`EP_TIME_WIDTH-1:0]     sim_time,
    input  flit_endpoint_pkg::flit_t      flit_in,
    input  logic                          flit_in_valid,
    output logic [`EP_VC_WIDTH-1:0]       credit_vc,
    output logic                          credit_valid,
    output flit_endpoint_pkg::ep_stats_t  stats,
    output logic                          error,
    output logic                          rx_empty
);
    import flit_endpoint_pkg::*;

    localparam logic [`EP_VC_WIDTH-1:0] LAST_VC = `EP_VC_WIDTH'(`EP_NUM_VCS - 1);

    flit_t                     rx_flit [`EP_NUM_VCS];
    logic [`EP_NUM_VCS-1:0]    rx_write;
    logic [`EP_NUM_VCS-1:0]    rx_read;
    logic [`EP_NUM_VCS-1:0]    rx_q_empty;
    logic [`EP_NUM_VCS-1:0]    rx_overflow;
    logic [`EP_VC_WIDTH-1:0]   prio;
    logic [`EP_VC_WIDTH-1:0]   sel_vc;
    logic                      eject;
    flit_t                     eject_flit;
    logic                      dest_mismatch;
    logic [`EP_TIME_WIDTH-1:0] latency;

    assign rx_empty = &rx_q_empty;

    genvar v;
    generate
        for (v = 0; v < `EP_NUM_VCS; v++)
        begin : g_input_queue
            assign rx_write[v] = flit_in_valid && (flit_in.vc == v);
            assign rx_read[v]  = eject && (sel_vc == v);

            vc_flit_queue u_queue (
                .clock      (clock),
                .reset      (reset),
                .write      (rx_write[v]),
                .read       (rx_read[v]),
                .write_flit (flit_in),
                .read_flit  (rx_flit[v]),
                .full       (),
                .empty      (rx_q_empty[v]),
                .overflow   (rx_overflow[v])
            );
        end
    endgenerate

    // First non-empty queue at or after the priority pointer
    always_comb
    begin
        int idx;
        eject  = 1'b0;
        sel_vc = '0;
        for (int i = 0; i < `EP_NUM_VCS; i++)
        begin
            idx = (int'(prio) + i) % `EP_NUM_VCS;
            if (!eject && !rx_q_empty[idx])
            begin
                eject  = 1'b1;
                sel_vc = idx[`EP_VC_WIDTH-1:0];
            end
        end
    end

    assign eject_flit    = rx_flit[sel_vc];
    assign dest_mismatch = eject && eject_flit.head &&
                           (eject_flit.body.head.dest != node_address);
    assign latency       = sim_time - flit_in.inj_time;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            prio         <= '0;
            credit_valid <= 1'b0;
            credit_vc    <= '0;
            error        <= 1'b0;
        end
        else
        begin
            // Served VC drops to lowest priority
            if (eject)
            begin
                prio <= (sel_vc == LAST_VC) ? '0 : sel_vc + 1'b1;
            end
            credit_valid <= eject;
            credit_vc    <= sel_vc;
            error        <= error | dest_mismatch | (|rx_overflow);
        end
    end

    // Counted when a measured tail arrives from the network
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            stats <= '0;
        end
        else if (flit_in_valid && flit_in.tail && flit_in.measure)
        begin
            stats.packets     <= stats.packets + 1'b1;
            stats.latency_sum <= stats.latency_sum + 32'(latency);
        end
    end

endmodule

`default_nettype wire

/* packet_injector.sv */
`default_nettype none

`include "flit_endpoint_settings.svh"

module packet_injector #(
    parameter logic [`EP_ADDR_WIDTH-1:0] node_address = '0
) (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [`EP_TIME_WIDTH-1:0]        sim_time,
    input  flit_endpoint_pkg::packet_desc_t  packet,
    input  logic                             packet_valid,
    output logic                             packet_request,
    input  logic [`EP_NUM_VCS-1:0]           queue_full,
    output flit_endpoint_pkg::flit_t         inj_flit,
    output logic [`EP_NUM_VCS-1:0]           inj_write
);
    import flit_endpoint_pkg::*;

    typedef enum logic {
        st_idle,
        st_sending
    } state_t;

    state_t                    state;
    packet_desc_t              desc;
    logic [`EP_TIME_WIDTH-1:0] inj_time;
    logic [`EP_LEN_WIDTH-1:0]  seq;
    logic                      first_flit;
    logic                      last_flit;
    logic                      flit_written;

    assign packet_request = (state == st_idle);
    assign first_flit     = (seq == '0);
    assign last_flit      = (seq == desc.len_m1);
    assign flit_written   = |inj_write;

    // Only the queue of the packet's VC is written and only when it has room
    always_comb
    begin
        for (int v = 0; v < `EP_NUM_VCS; v++)
        begin
            inj_write[v] = (state == st_sending) && (desc.vc == v) && !queue_full[v];
        end
    end

    always_comb
    begin
        inj_flit          = '0;
        inj_flit.head     = first_flit;
        inj_flit.tail     = last_flit;
        inj_flit.measure  = desc.measure;
        inj_flit.vc       = desc.vc;
        inj_flit.inj_time = inj_time;
        if (first_flit)
        begin
            inj_flit.body.head.dest = desc.dest;
            inj_flit.body.head.src  = node_address;
        end
        else
        begin
            inj_flit.body.payload[`EP_LEN_WIDTH-1:0] = seq;
        end
    end

    // Descriptor and acceptance time hold for the whole packet
    always_ff @(posedge clock)
    begin
        if (packet_request && packet_valid)
        begin
            desc     <= packet;
            inj_time <= sim_time;
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= st_idle;
            seq   <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (packet_valid)
                    begin
                        state <= st_sending;
                        seq   <= '0;
                    end
                end
                st_sending:
                begin
                    // A full queue simply holds the current flit
                    if (flit_written)
                    begin
                        seq <= seq + 1'b1;
                        if (last_flit)
                        begin
                            state <= st_idle;
                        end
                    end
                end
                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* tb_flit_endpoint.sv */
`default_nettype none

`include "flit_endpoint_settings.svh"

module tb_flit_endpoint;
    import flit_endpoint_pkg::*;

    localparam logic [`EP_ADDR_WIDTH-1:0] NODE = 8'h2a;
    localparam int NUM_PACKETS = 24;
    localparam int NUM_ARRIVALS = 40;
    // Random and back-pressure packets plus margin for the receive tests
    localparam int CYCLE_LIMIT = 200 * (NUM_PACKETS + 2) + 1000;

    logic                      clock = 1'b0;
    logic                      reset = 1'b1;
    logic [`EP_TIME_WIDTH-1:0] sim_time = '0;
    packet_desc_t              packet = '0;
    logic                      packet_valid = 1'b0;
    logic                      packet_request;
    flit_t                     flit_out [`EP_NUM_VCS];
    logic [`EP_NUM_VCS-1:0]    flit_out_valid;
    logic [`EP_NUM_VCS-1:0]    dequeue = '0;
    flit_t                     flit_in = '0;
    logic                      flit_in_valid = 1'b0;
    logic [`EP_VC_WIDTH-1:0]   credit_vc;
    logic                      credit_valid;
    ep_stats_t                 stats;
    logic                      error;
    logic                      is_quiescent;

    // Reference model
    flit_t                  exp_mem [`EP_NUM_VCS][256];
    logic [7:0]             wr_idx [`EP_NUM_VCS];
    logic [7:0]             rd_idx [`EP_NUM_VCS];
    int                     arr_cnt [`EP_NUM_VCS];
    int                     cred_cnt [`EP_NUM_VCS];
    logic [15:0]            exp_pkts;
    logic [31:0]            exp_lat;

    logic                   error_ok = 1'b0;
    logic                   error_seen = 1'b0;
    logic                   deq_random = 1'b0;
    logic [`EP_NUM_VCS-1:0] deq_fixed = '0;
    logic [31:0]            lfsr = 32'hc066_1e66;
    int                     cycles = 0;
    int                     tx_errs = 0;
    int                     rx_errs = 0;
    int                     other_errs = 0;

    flit_endpoint #(
        .node_address (NODE)
    ) DUT (
        .clock          (clock),
        .reset          (reset),
        .sim_time       (sim_time),
        .packet         (packet),
        .packet_valid   (packet_valid),
        .packet_request (packet_request),
        .flit_out       (flit_out),
        .flit_out_valid (flit_out_valid),
        .dequeue        (dequeue),
        .flit_in        (flit_in),
        .flit_in_valid  (flit_in_valid),
        .credit_vc      (credit_vc),
        .credit_valid   (credit_valid),
        .stats          (stats),
        .error          (error),
        .is_quiescent   (is_quiescent)
    );

    always #2 clock = ~clock;

    always @(posedge clock)
    begin
        sim_time <= sim_time + 16'd1;
    end

    always @(posedge clock)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    always @(posedge clock)
    begin
        flit_t       f;
        logic [15:0] lat;
        if (reset)
        begin
            for (int v = 0; v < `EP_NUM_VCS; v++)
            begin
                wr_idx[v]   <= '0;
                rd_idx[v]   <= '0;
                arr_cnt[v]  <= 0;
                cred_cnt[v] <= 0;
            end
            exp_pkts <= '0;
            exp_lat  <= '0;
        end
        else
        begin
            for (int v = 0; v < `EP_NUM_VCS; v++)
            begin
                if (dequeue[v] && flit_out_valid[v])
                begin
                    rd_idx[v] <= rd_idx[v] + 8'd1;
                end
            end
            // Accepted descriptor expands into len_m1 + 1 flits stamped with this time
            if (packet_valid && packet_request)
            begin
                for (int i = 0; i <= int'(packet.len_m1); i++)
                begin
                    f          = '0;
                    f.head     = (i == 0);
                    f.tail     = (i == int'(packet.len_m1));
                    f.measure  = packet.measure;
                    f.vc       = packet.vc;
                    f.inj_time = sim_time;
                    if (i == 0)
                    begin
                        f.body.head.dest = packet.dest;
                        f.body.head.src  = NODE;
                    end
                    else
                    begin
                        f.body.payload = 16'(i);
                    end
                    exp_mem[packet.vc][wr_idx[packet.vc] + 8'(i)] = f;
                end
                wr_idx[packet.vc] <= wr_idx[packet.vc] + 8'(packet.len_m1) + 8'd1;
            end
            if (flit_in_valid)
            begin
                arr_cnt[flit_in.vc] <= arr_cnt[flit_in.vc] + 1;
                if (flit_in.tail && flit_in.measure)
                begin
                    lat      = sim_time - flit_in.inj_time;
                    exp_pkts <= exp_pkts + 16'd1;
                    exp_lat  <= exp_lat + 32'(lat);
                end
            end
            if (credit_valid)
            begin
                cred_cnt[credit_vc] <= cred_cnt[credit_vc] + 1;
            end
        end
    end

    generate
        for (genvar v = 0; v < `EP_NUM_VCS; v++)
        begin : g_vc_check
            // Dequeued flit must be the oldest one still expected on this VC
            a_flit_match: assert property (@(posedge clock) disable iff (reset)
                !(dequeue[v] && flit_out_valid[v]) || (flit_out[v] == exp_mem[v][rd_idx[v]]))
            else
            begin
                tx_errs++;
                $display("ERR %0t: VC %0d flit %h, expected %h", $time, v,
                         flit_out[v], exp_mem[v][rd_idx[v]]);
            end

            a_no_extra: assert property (@(posedge clock) disable iff (reset)
                !flit_out_valid[v] || (rd_idx[v] != wr_idx[v]))
            else
            begin
                tx_errs++;
                $display("ERR %0t: VC %0d shows a flit that was never injected", $time, v);
            end
        end
    endgenerate

    a_credit: assert property (@(posedge clock) disable iff (reset)
        !credit_valid || (cred_cnt[credit_vc] < arr_cnt[credit_vc]))
    else
    begin
        rx_errs++;
        $display("ERR %0t: credit on VC %0d without a matching arrival", $time, credit_vc);
    end

    a_stats: assert property (@(posedge clock) disable iff (reset)
        (stats.packets == exp_pkts) && (stats.latency_sum == exp_lat))
    else
    begin
        rx_errs++;
        $display("ERR %0t: stats %0d/%0d, expected %0d/%0d", $time,
                 stats.packets, stats.latency_sum, exp_pkts, exp_lat);
    end

    a_error_low: assert property (@(posedge clock) disable iff (reset) error_ok || !error)
    else
    begin
        rx_errs++;
        $display("ERR %0t: error raised without a cause", $time);
    end

    a_error_sticky: assert property (@(posedge clock) disable iff (reset) !error_seen || error)
    else
    begin
        rx_errs++;
        $display("ERR %0t: error dropped before reset", $time);
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        assert (ok)
        else
        begin
            other_errs++;
            $display("ERR %0t: %s", $time, what);
        end
    endtask

    // One clock with the strobes falling back low unless driven again
    task automatic tick();
        logic [31:0] r;
        @(posedge clock);
        packet_valid  <= 1'b0;
        flit_in_valid <= 1'b0;
        if (deq_random)
        begin
            rand_bits(`EP_NUM_VCS, r);
            dequeue <= r[`EP_NUM_VCS-1:0];
        end
        else
        begin
            dequeue <= deq_fixed;
        end
    endtask

    task automatic check_idle();
        check_true(packet_request && is_quiescent, "request or quiescent low when idle");
        check_true((flit_out_valid == '0) && !credit_valid && !error, "outputs active when idle");
    endtask

    task automatic send_packet(input packet_desc_t d);
        tick();
        while (!packet_request)
        begin
            tick();
        end
        packet       <= d;
        packet_valid <= 1'b1;
        tick();
    endtask

    task automatic random_packet();
        packet_desc_t d;
        logic [31:0]  r;
        rand_bits(`EP_ADDR_WIDTH, r);
        d.dest = r[`EP_ADDR_WIDTH-1:0];
        rand_bits(`EP_LEN_WIDTH, r);
        d.len_m1 = r[`EP_LEN_WIDTH-1:0];
        rand_bits(`EP_VC_WIDTH, r);
        d.vc = r[`EP_VC_WIDTH-1:0];
        rand_bits(1, r);
        d.measure = r[0];
        send_packet(d);
    endtask

    task automatic send_flit(input flit_t f);
        flit_in       <= f;
        flit_in_valid <= 1'b1;
        tick();
    endtask

    // Heads are addressed here so only the dedicated test trips the check
    task automatic random_arrival();
        flit_t       f;
        logic [31:0] r;
        f = '0;
        rand_bits(3 + `EP_VC_WIDTH, r);
        f.head    = r[0];
        f.tail    = r[1];
        f.measure = r[2];
        f.vc      = r[3 +: `EP_VC_WIDTH];
        rand_bits(6, r);
        f.inj_time = sim_time - 16'(r[5:0]);
        rand_bits(16, r);
        if (f.head)
        begin
            f.body.head.dest = NODE;
            f.body.head.src  = r[7:0];
        end
        else
        begin
            f.body.payload = r[15:0];
        end
        send_flit(f);
        rand_bits(1, r);
        if (r[0])
        begin
            tick();
        end
    endtask

    task automatic drain();
        tick();
        while (!is_quiescent || credit_valid)
        begin
            tick();
        end
        repeat (2) tick();
        for (int v = 0; v < `EP_NUM_VCS; v++)
        begin
            check_true(rd_idx[v] == wr_idx[v], "flits still missing on an output VC");
            check_true(cred_cnt[v] == arr_cnt[v], "credit count differs from arrivals");
        end
    endtask

    initial
    begin
        packet_desc_t d;
        flit_t        f;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        tick();
        check_idle();

        // Random packets with random network dequeue
        deq_random = 1'b1;
        for (int n = 0; n < NUM_PACKETS; n++)
        begin
            random_packet();
        end
        drain();

        // Eight flits on a blocked VC1 overrun the four slot queue
        deq_random = 1'b0;
        deq_fixed  = 2'b01;
        d          = '0;
        d.dest     = 8'h3c;
        d.len_m1   = 3'd7;
        d.vc       = 1'b1;
        d.measure  = 1'b1;
        send_packet(d);
        d.dest   = 8'h5a;
        d.len_m1 = 3'd1;
        repeat (12)
        begin
            packet       <= d;
            packet_valid <= 1'b1;
            tick();
            check_true(!packet_request, "injector took a descriptor while stalled");
        end
        deq_fixed = 2'b11;
        while (!packet_request)
        begin
            packet_valid <= 1'b1;
            tick();
        end
        drain();

        deq_fixed = '0;
        for (int n = 0; n < NUM_ARRIVALS; n++)
        begin
            random_arrival();
        end
        // Back-to-back burst into VC0 drained at one flit per cycle
        for (int i = 0; i < `EP_QUEUE_DEPTH + 2; i++)
        begin
            f              = '0;
            f.tail         = 1'b1;
            f.measure      = 1'b1;
            f.inj_time     = sim_time - 16'd3;
            f.body.payload = 16'(i);
            send_flit(f);
        end
        drain();

        // Head for another node
        error_ok            <= 1'b1;
        f                   = '0;
        f.head              = 1'b1;
        f.tail              = 1'b1;
        f.vc                = 1'b1;
        f.inj_time          = sim_time;
        f.body.head.dest    = 8'h55;
        f.body.head.src     = 8'h07;
        send_flit(f);
        while (!error)
        begin
            tick();
        end
        error_seen <= 1'b1;
        repeat (8) tick();
        reset      <= 1'b1;
        error_seen <= 1'b0;
        repeat (3) tick();
        reset    <= 1'b0;
        error_ok <= 1'b0;
        tick();
        check_idle();
        repeat (2) tick();

        $display("Errors: transmit %0d, receive %0d, other %0d", tx_errs, rx_errs, other_errs);
        if (tx_errs + rx_errs + other_errs == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vc_flit_queue.sv */
`default_nettype none

`include "flit_endpoint_settings.svh"

module vc_flit_queue (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     write,
    input  logic                     read,
    input  flit_endpoint_pkg::flit_t write_flit,
    output flit_endpoint_pkg::flit_t read_flit,
    output logic                     full,
    output logic                     empty,
    output logic                     overflow
);
    import flit_endpoint_pkg::*;

    localparam int PTR_WIDTH = $clog2(`EP_QUEUE_DEPTH);
    localparam int CNT_WIDTH = $clog2(`EP_QUEUE_DEPTH + 1);
    localparam logic [PTR_WIDTH-1:0] LAST_SLOT = PTR_WIDTH'(`EP_QUEUE_DEPTH - 1);

    flit_t                mem [`EP_QUEUE_DEPTH];
    logic [PTR_WIDTH-1:0] head_ptr;
    logic [PTR_WIDTH-1:0] tail_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic                 do_write;
    logic                 do_read;

    assign full      = (count == CNT_WIDTH'(`EP_QUEUE_DEPTH));
    assign empty     = (count == '0);
    assign do_write  = write && !full;
    assign do_read   = read && !empty;
    // One-cycle pulse when a write meets a full queue and the flit is dropped
    assign overflow  = write && full;
    assign read_flit = mem[head_ptr];

    always_ff @(posedge clock)
    begin
        if (do_write)
        begin
            mem[tail_ptr] <= write_flit;
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end
        else
        begin
            if (do_write)
            begin
                tail_ptr <= (tail_ptr == LAST_SLOT) ? '0 : tail_ptr + 1'b1;
            end
            if (do_read)
            begin
                head_ptr <= (head_ptr == LAST_SLOT) ? '0 : head_ptr + 1'b1;
            end
            // Simultaneous read and write leaves the count alone
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire
